// ==== hdl/cart_loader_macros.svh ====
`ifndef CART_LOADER_MACROS_SVH
`define CART_LOADER_MACROS_SVH

// memory side widths, in 16-bit words.
`define CL_ADDR_BITS 21
`define CL_DATA_BITS 16

// the command queue depth doubles as the host credit count after reset.
`define CL_CMD_DEPTH 4

`define CL_WR_DEPTH 4       // entries in each memory write queue.

// each memory grants this many outstanding writes after reset.
`define CL_MEM_CREDITS 2

`endif

// ==== hdl/cart_loader_pkg.sv ====
`include "cart_loader_macros.svh"

package cart_loader_pkg;

    typedef logic [`CL_ADDR_BITS-1:0] cl_addr_t;
    typedef logic [`CL_DATA_BITS-1:0] cl_data_t;
    typedef logic [31:0]              cl_arg_t;

    // command codes as sent by the host on the command channel.
    typedef enum logic [5:0] {
        write_prg = 6'd1,
        write_chr = 6'd2,
        set_load  = 6'd3
    } cl_cmd_e;

    typedef enum logic [1:0] {
        status_ok     = 2'd1,
        status_reject = 2'd2
    } cl_status_e;

    typedef struct packed {
        cl_cmd_e cmd;
        cl_arg_t arg;       // upper half is the address, lower half the data for writes.
    } cl_req_t;

    typedef struct packed {
        cl_status_e status;
        cl_arg_t    arg;
    } cl_resp_t;

    typedef struct packed {
        cl_addr_t addr;
        cl_data_t data;
    } mem_write_t;

endpackage

// ==== hdl/cart_loader_top.sv ====
`timescale 1ns/1ps

module cart_loader_top
    import cart_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  cl_req_t    req,
    output logic       req_credit,
    output logic       resp_valid,
    output cl_resp_t   resp,
    output logic       prg_mem_valid,
    output mem_write_t prg_mem_wr,
    input  logic       prg_mem_credit,
    output logic       chr_mem_valid,
    output mem_write_t chr_mem_wr,
    input  logic       chr_mem_credit,
    output logic       write_active
);
    logic       cmd_valid;
    cl_req_t    cmd;
    logic       cmd_pop;
    logic       prg_wr_valid;
    mem_write_t prg_wr;
    logic       prg_wr_ready;
    logic       chr_wr_valid;
    mem_write_t chr_wr;
    logic       chr_wr_ready;

    cmd_receiver receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_pop    (cmd_pop)
    );

    loader_api api (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_pop      (cmd_pop),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .prg_wr_valid (prg_wr_valid),
        .prg_wr       (prg_wr),
        .prg_wr_ready (prg_wr_ready),
        .chr_wr_valid (chr_wr_valid),
        .chr_wr       (chr_wr),
        .chr_wr_ready (chr_wr_ready),
        .write_active (write_active)
    );

    mem_write_port prg_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (prg_wr_valid),
        .wr         (prg_wr),
        .wr_ready   (prg_wr_ready),
        .mem_valid  (prg_mem_valid),
        .mem_wr     (prg_mem_wr),
        .mem_credit (prg_mem_credit)
    );

    mem_write_port chr_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (chr_wr_valid),
        .wr         (chr_wr),
        .wr_ready   (chr_wr_ready),
        .mem_valid  (chr_mem_valid),
        .mem_wr     (chr_mem_wr),
        .mem_credit (chr_mem_credit)
    );

endmodule

// ==== hdl/cmd_receiver.sv ====
`timescale 1ns/1ps
`include "cart_loader_macros.svh"

module cmd_receiver
    import cart_loader_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req_valid,
    input  cl_req_t req,
    output logic    req_credit,
    output logic    cmd_valid,
    output cl_req_t cmd,
    input  logic    cmd_pop
);
    localparam int DEPTH = `CL_CMD_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cl_req_t          queue [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign cmd_valid = (count != '0);
    assign cmd       = queue[rd_ptr];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            req_credit <= cmd_pop;      // one credit back per consumed command.
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (cmd_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, cmd_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the host only sends while it holds a credit, so the queue never overflows.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (count != CNT_W'(DEPTH)))
        else $error("cmd_receiver: host pushed into a full command queue");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_pop |-> cmd_valid)
        else $error("cmd_receiver: pop from an empty command queue");

endmodule

// ==== hdl/loader_api.sv ====
`timescale 1ns/1ps

module loader_api
    import cart_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  cl_req_t    cmd,
    output logic       cmd_pop,
    output logic       resp_valid,
    output cl_resp_t   resp,
    output logic       prg_wr_valid,
    output mem_write_t prg_wr,
    input  logic       prg_wr_ready,
    output logic       chr_wr_valid,
    output mem_write_t chr_wr,
    input  logic       chr_wr_ready,
    output logic       write_active
);
    logic       load_mode;
    logic       prg_sel;
    logic       chr_sel;
    logic       can_pop;
    cl_status_e status_next;
    mem_write_t wr_word;

    // both memories take the same word layout from the argument.
    assign wr_word.addr = cl_addr_t'(cmd.arg[31:16]);
    assign wr_word.data = cmd.arg[15:0];

    always_comb begin
        prg_sel     = 1'b0;
        chr_sel     = 1'b0;
        can_pop     = 1'b1;
        status_next = status_reject;
        case (cmd.cmd)
            write_prg: begin
                if (load_mode) begin
                    prg_sel     = 1'b1;
                    can_pop     = prg_wr_ready;     // stall until the port has room.
                    status_next = status_ok;
                end
            end
            write_chr: begin
                if (load_mode) begin
                    chr_sel     = 1'b1;
                    can_pop     = chr_wr_ready;
                    status_next = status_ok;
                end
            end
            set_load: begin
                status_next = status_ok;
            end
            default: begin
                status_next = status_reject;
            end
        endcase
    end

    assign cmd_pop      = cmd_valid && can_pop;
    assign prg_wr_valid = cmd_valid && prg_sel;
    assign chr_wr_valid = cmd_valid && chr_sel;
    assign prg_wr       = wr_word;
    assign chr_wr       = wr_word;
    assign write_active = load_mode;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            load_mode  <= 1'b1;     // loading starts enabled out of reset.
        end else begin
            resp_valid <= cmd_pop;
            if (cmd_pop && (cmd.cmd == set_load)) begin
                load_mode <= cmd.arg[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            resp.status <= status_next;
            resp.arg    <= '0;
        end
    end

    // a write the port cannot take yet stays on offer unchanged until it is taken.
    a_prg_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (prg_wr_valid && !prg_wr_ready) |=> (prg_wr_valid && $stable(prg_wr)))
        else $error("loader_api: stalled PRG write was dropped or changed");

    a_chr_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (chr_wr_valid && !chr_wr_ready) |=> (chr_wr_valid && $stable(chr_wr)))
        else $error("loader_api: stalled CHR write was dropped or changed");

endmodule

// ==== hdl/mem_write_port.sv ====
`timescale 1ns/1ps
`include "cart_loader_macros.svh"

module mem_write_port
    import cart_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  mem_write_t wr,
    output logic       wr_ready,
    output logic       mem_valid,
    output mem_write_t mem_wr,
    input  logic       mem_credit
);
    localparam int DEPTH       = `CL_WR_DEPTH;
    localparam int PTR_W       = $clog2(DEPTH);
    localparam int CNT_W       = $clog2(DEPTH + 1);
    localparam int MAX_CREDITS = `CL_MEM_CREDITS;
    localparam int CRD_W       = $clog2(MAX_CREDITS + 1);

    mem_write_t       queue [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             push;

    assign wr_ready  = (count != CNT_W'(DEPTH));
    assign push      = wr_valid && wr_ready;
    // the head leaves as soon as the memory has granted room for it.
    assign mem_valid = (count != '0) && (credits != '0);
    assign mem_wr    = queue[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(MAX_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, mem_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a returned credit and an issue in the same cycle cancel out.
            case ({mem_valid, mem_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // the memory never hands back more credits than it granted.
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRD_W'(MAX_CREDITS))
        else $error("mem_write_port: memory returned too many credits");

endmodule

// ==== list.f ====
+incdir+hdl
hdl/cart_loader_pkg.sv
hdl/cmd_receiver.sv
hdl/loader_api.sv
hdl/mem_write_port.sv
hdl/cart_loader_top.sv
tests/cart_loader_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cart_loader_tb \
    -f list.f -o cart_loader_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/cart_loader_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended without passing, see sim.log"; exit 1; }
echo "simulation passed"

// ==== tests/cart_loader_tb.sv ====
`timescale 1ns/1ps
`include "cart_loader_macros.svh"

module cart_loader_tb
    import cart_loader_pkg::*;
();
    typedef struct packed {
        logic [5:0] code;
        cl_arg_t    arg;
        cl_status_e status;
        logic       active;     // write_active expected once the response is out.
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    cl_req_t     req;
    logic        req_credit;
    logic        resp_valid;
    cl_resp_t    resp;
    logic        prg_mem_valid;
    mem_write_t  prg_mem_wr;
    logic        prg_mem_credit;
    logic        chr_mem_valid;
    mem_write_t  chr_mem_wr;
    logic        chr_mem_credit;
    logic        write_active;

    entry_t      tests[$];
    string       names[$];
    cl_resp_t    exp_resp[$];
    logic        exp_active[$];
    string       resp_names[$];
    mem_write_t  prg_sb[$];
    mem_write_t  chr_sb[$];
    string       prg_names[$];
    string       chr_names[$];
    int          prg_due[$];
    int          chr_due[$];
    logic [31:0] rng = 32'h92d6;
    int          credits;
    int          cycle;
    int          resp_count;

    cart_loader_top dut0 (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_resp(string name, cl_resp_t exp, cl_resp_t act);
        if (act !== exp)
            report_failure($sformatf("error %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_write(string name, string mem, mem_write_t exp, mem_write_t act);
        if (act !== exp)
            report_failure($sformatf("error %s (%s): expected %h, got %h", name, mem, exp, act));
    endtask

    task automatic check_active(string name, logic exp, logic act);
        if (act !== exp)
            report_failure($sformatf("error %s: expected %b, got %b", name, exp, act));
    endtask

    task automatic add_entry(string name, logic [5:0] code, cl_arg_t arg,
                             cl_status_e status, logic active);
        tests.push_back('{code: code, arg: arg, status: status, active: active});
        names.push_back(name);
    endtask

    task automatic build_table();
        add_entry("prg write", 6'd1, 32'h0010_1234, status_ok, 1'b1);
        add_entry("chr write", 6'd2, 32'h0020_abcd, status_ok, 1'b1);
        add_entry("prg write high address", 6'd1, 32'hffff_0001, status_ok, 1'b1);
        add_entry("unknown code 0", 6'd0, 32'h0030_5555, status_reject, 1'b1);
        add_entry("unknown code 7", 6'd7, 32'h0031_6666, status_reject, 1'b1);
        add_entry("load off", 6'd3, 32'h0000_0000, status_ok, 1'b0);
        add_entry("prg write while off", 6'd1, 32'h0040_1111, status_reject, 1'b0);
        add_entry("chr write while off", 6'd2, 32'h0041_2222, status_reject, 1'b0);
        add_entry("unknown code 7 while off", 6'd7, 32'h0042_3333, status_reject, 1'b0);
        add_entry("load on", 6'd3, 32'h0000_0001, status_ok, 1'b1);
        add_entry("prg write after load on", 6'd1, 32'h0050_4444, status_ok, 1'b1);
        add_entry("chr write after load on", 6'd2, 32'h0051_7777, status_ok, 1'b1);
        // long enough to fill both the port queue and the command queue.
        for (int i = 0; i < `CL_WR_DEPTH + `CL_CMD_DEPTH + 4; i++) begin
            add_entry($sformatf("prg burst %0d", i), 6'd1, next_rand(), status_ok, 1'b1);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && req_credit) begin
            credits++;
            if (credits > `CL_CMD_DEPTH)
                report_failure("the DUT returned more host credits than it granted");
        end
    end

    always @(posedge clk) begin
        if (rst_n && resp_valid) begin
            if (exp_resp.size() == 0)
                report_failure("a response arrived with no command outstanding");
            check_resp(resp_names[0], exp_resp[0], resp);
            check_active(resp_names[0], exp_active[0], write_active);
            void'(exp_resp.pop_front());
            void'(exp_active.pop_front());
            void'(resp_names.pop_front());
            resp_count++;
        end
    end

    // both memory models share one block so the random sequence stays fixed.
    always @(posedge clk) begin
        if (rst_n) begin
            cycle++;
            if (prg_mem_valid) begin
                if (prg_sb.size() == 0 || prg_due.size() >= `CL_MEM_CREDITS)
                    report_failure("PRG memory got a write it did not expect or grant");
                check_write(prg_names.pop_front(), "prg", prg_sb.pop_front(), prg_mem_wr);
                prg_due.push_back(cycle + int'(next_rand() % 8));
            end
            if (chr_mem_valid) begin
                if (chr_sb.size() == 0 || chr_due.size() >= `CL_MEM_CREDITS)
                    report_failure("CHR memory got a write it did not expect or grant");
                check_write(chr_names.pop_front(), "chr", chr_sb.pop_front(), chr_mem_wr);
                chr_due.push_back(cycle + int'(next_rand() % 8));
            end
        end
        #1;
        prg_mem_credit = (prg_due.size() != 0) && (prg_due[0] <= cycle);
        chr_mem_credit = (chr_due.size() != 0) && (chr_due[0] <= cycle);
        if (prg_mem_credit) void'(prg_due.pop_front());
        if (chr_mem_credit) void'(chr_due.pop_front());
    end

    initial begin
        entry_t     e;
        mem_write_t w;
        logic       load_model;
        int         wait_cycles;

        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        prg_mem_credit = 1'b0;
        chr_mem_credit = 1'b0;
        credits        = `CL_CMD_DEPTH;
        cycle          = 0;
        resp_count     = 0;
        load_model     = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_active("after reset", 1'b1, write_active);
        foreach (tests[i]) begin
            e           = tests[i];
            wait_cycles = 0;
            while (credits == 0) begin
                req_valid = 1'b0;
                @(posedge clk);
                #1;
                wait_cycles++;
                if (wait_cycles > 2000)
                    report_failure("timed out waiting for a host credit");
            end
            req_valid = 1'b1;
            req.cmd   = cl_cmd_e'(e.code);
            req.arg   = e.arg;
            credits--;
            exp_resp.push_back('{status: e.status, arg: '0});
            exp_active.push_back(e.active);
            resp_names.push_back(names[i]);
            // the upper argument half lands in the zero-extended address and the lower in data.
            w = {{(`CL_ADDR_BITS - 16){1'b0}}, e.arg};
            if (load_model && e.code == 6'd1) begin
                prg_sb.push_back(w);
                prg_names.push_back(names[i]);
            end
            if (load_model && e.code == 6'd2) begin
                chr_sb.push_back(w);
                chr_names.push_back(names[i]);
            end
            if (e.code == 6'd3) load_model = e.arg[0];
            @(posedge clk);
            #1;
        end
        req_valid   = 1'b0;
        wait_cycles = 0;
        while (resp_count < tests.size() || prg_sb.size() != 0 || chr_sb.size() != 0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 2000)
                report_failure("timed out waiting for responses and memory writes");
        end
        repeat (10) @(posedge clk);
        if (prg_sb.size() == 0 && chr_sb.size() == 0 && exp_resp.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_failure("expected writes or responses were left over at the end");
        end
    end

endmodule
